/* pt2272_pkg.sv */
`default_nettype none

package pt2272_pkg;

    // Two-bit trit codes, also the encoding of the ADDR register
    typedef enum logic [1:0] {
        TRIT_ZERO  = 2'b00,             // Bit-pulses 0,0
        TRIT_FLOAT = 2'b01,             // Bit-pulses 0,1
        TRIT_BAD   = 2'b10,             // Bit-pulses 1,0, never sent by an encoder
        TRIT_ONE   = 2'b11              // Bit-pulses 1,1
    } pt_trit_e;

    // One received frame, seen as a trit list or as address and data fields
    typedef union packed {
        pt_trit_e [11:0] raw;           // Index 0 is the first trit on the line
        struct packed {
            pt_trit_e [3:0] data;       // Trits 8 to 11
            pt_trit_e [7:0] addr;       // Trits 0 to 7, same layout as ADDR
        } fields;
    } pt_frame_u;

    // Pulse timing, all in units of the encoder base period
    localparam int SHORT_ALPHA       = 4;    // Short phase
    localparam int LONG_ALPHA        = 12;   // Long phase
    localparam int SYNC_LOW_ALPHA    = 124;  // Nominal sync low phase
    localparam int SYNC_DETECT_ALPHA = 120;  // Sync accepted at this low length
    localparam int TOL_ALPHA         = 1;    // Window half width for short and long
    localparam int SILENCE_ALPHA     = 256;  // Line idle from here on
    localparam int TRITS_PER_FRAME   = 12;

    // APB register map
    localparam logic [7:0] REG_CTRL   = 8'h00;  // Bit 0 enable
    localparam logic [7:0] REG_ADDR   = 8'h04;  // 8 trit codes
    localparam logic [7:0] REG_STATUS = 8'h08;  // vt and confirm count, read only
    localparam logic [7:0] REG_DATA   = 8'h0C;  // Confirmed data, read only
    localparam logic [7:0] REG_FRAME  = 8'h10;  // Last complete frame, read only

endpackage

`default_nettype wire

/* pt2272_sym_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Symbol events from the pulse meter to the frame checker
interface pt2272_sym_if import pt2272_pkg::*; ();

    logic     sym_valid;    // One-cycle pulse, sym_trit holds a new trit
    pt_trit_e sym_trit;     // Decoded trit, meaningful with sym_valid
    logic     sym_sync;     // One-cycle pulse, sync pulse seen
    logic     sym_error;    // One-cycle pulse, malformed pulse or pair
    logic     silence;      // Level, line low for SILENCE_ALPHA or more

    // Producer side, pulse meter
    modport meter (
        output sym_valid,
        output sym_trit,
        output sym_sync,
        output sym_error,
        output silence
    );

    // Consumer side, frame checker
    modport chk (
        input sym_valid,
        input sym_trit,
        input sym_sync,
        input sym_error,
        input silence
    );

endinterface

`default_nettype wire

/* pt2272_pulse_meter.sv */
`timescale 1ns/1ps
`default_nettype none

module pt2272_pulse_meter import pt2272_pkg::*; #(
    parameter int CLK_PER_ALPHA = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        cod_i,
    pt2272_sym_if.meter sym_o
);

    localparam int TW = $clog2(CLK_PER_ALPHA + 1);  // Divider width
    localparam int HW = 8;                          // High counter, saturating
    localparam int LW = $clog2(SILENCE_ALPHA + 1);  // Low counter, stops at silence

    logic          cod_s1;
    logic          cod_s2;
    logic          cod_d;
    logic          rise;
    logic [TW-1:0] div_cnt;
    logic          tick;
    logic [HW-1:0] high_cnt;
    logic [LW-1:0] low_cnt;
    logic          ignore_q;    // Next rise only restarts the measurement
    logic          half_q;      // First bit-pulse of a pair held
    logic          first_q;     // Value of that first bit-pulse
    logic          bit_ok;
    logic          bit_val;
    logic          sync_hit;
    logic          pair_done;

    function automatic logic in_window(input int cnt, input int centre);
        return (cnt >= centre - TOL_ALPHA) && (cnt <= centre + TOL_ALPHA);
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cod_s1 <= 1'b0;
            cod_s2 <= 1'b0;
            cod_d  <= 1'b0;
        end else begin
            cod_s1 <= cod_i;                        // Two-flop synchronizer
            cod_s2 <= cod_s1;
            cod_d  <= cod_s2;                       // Previous level for edge detect
        end
    end

    assign rise = cod_s2 & ~cod_d;
    assign tick = (div_cnt == TW'(CLK_PER_ALPHA - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt  <= '0;
            high_cnt <= '0;
            low_cnt  <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;  // Free running alpha divider
            if (rise) begin
                high_cnt <= '0;                     // New pulse starts here
                low_cnt  <= '0;
            end else if (tick) begin
                if (cod_s2) begin
                    if (high_cnt != '1) high_cnt <= high_cnt + 1'b1;
                end else if (low_cnt != LW'(SILENCE_ALPHA)) begin
                    low_cnt <= low_cnt + 1'b1;
                end
            end
        end
    end

    // Short high with long low is a 0, long high with short low is a 1
    assign bit_ok = (in_window(high_cnt, SHORT_ALPHA) && in_window(low_cnt, LONG_ALPHA))
                 || (in_window(high_cnt, LONG_ALPHA) && in_window(low_cnt, SHORT_ALPHA));
    assign bit_val = in_window(high_cnt, LONG_ALPHA);
    assign sync_hit = ~cod_s2 && !ignore_q && in_window(high_cnt, SHORT_ALPHA)
                   && (low_cnt == LW'(SYNC_DETECT_ALPHA));   // Fires before the next rise
    assign pair_done = rise && !ignore_q && bit_ok && half_q;
    assign sym_o.silence = (low_cnt == LW'(SILENCE_ALPHA));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sym_o.sym_valid <= 1'b0;
            sym_o.sym_sync  <= 1'b0;
            sym_o.sym_error <= 1'b0;
            ignore_q        <= 1'b1;                // First rise after reset is not a pulse end
            half_q          <= 1'b0;
            first_q         <= 1'b0;
        end else begin
            sym_o.sym_valid <= 1'b0;
            sym_o.sym_sync  <= 1'b0;
            sym_o.sym_error <= 1'b0;
            if (sync_hit) begin
                sym_o.sym_sync <= 1'b1;
                ignore_q       <= 1'b1;             // Rise after sync closes no pulse
                half_q         <= 1'b0;
            end else if (rise) begin
                if (ignore_q) begin
                    ignore_q <= 1'b0;
                    half_q   <= 1'b0;
                end else if (!bit_ok) begin
                    sym_o.sym_error <= 1'b1;        // Phase outside both windows
                    half_q          <= 1'b0;
                end else if (!half_q) begin
                    half_q  <= 1'b1;
                    first_q <= bit_val;
                end else begin
                    half_q <= 1'b0;
                    if (first_q && !bit_val) sym_o.sym_error <= 1'b1;  // Pair 1,0
                    else sym_o.sym_valid <= 1'b1;
                end
            end else if (sym_o.silence) begin
                ignore_q <= 1'b1;
                half_q   <= 1'b0;
            end
        end
    end

    // Trit code is the two bit-pulses side by side
    always_ff @(posedge clk) begin
        if (pair_done) sym_o.sym_trit <= pt_trit_e'({first_q, bit_val});
    end

endmodule

`default_nettype wire

/* pt2272_frame_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module pt2272_frame_checker import pt2272_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    pt2272_sym_if.chk    sym_i,
    input  logic         enable_i,
    input  logic [15:0]  addr_cfg_i,
    output logic         frame_done_o,
    output pt_frame_u    frame_o,
    output logic         confirm_o,
    output logic         vt_o,
    output logic [3:0]   data_o
);

    pt_frame_u  asm_q;          // Frame under assembly
    logic [3:0] trit_cnt;       // Saturates one above a full frame
    logic       bad_q;          // Error seen since the last sync
    logic       prev_match_q;   // Last complete frame matched
    logic       addr_match;
    logic       data_ok;
    logic       match;
    logic       frame_take;
    logic       confirm;
    logic [3:0] data_nxt;

    assign addr_match = (asm_q.fields.addr == addr_cfg_i);  // Float only matches Float

    always_comb begin
        data_ok  = 1'b1;
        data_nxt = '0;
        for (int i = 0; i < 4; i++) begin
            if (asm_q.fields.data[i] == TRIT_FLOAT) data_ok = 1'b0;
            data_nxt[i] = (asm_q.fields.data[i] == TRIT_ONE);
        end
    end

    assign match      = addr_match && data_ok;
    assign frame_take = enable_i && sym_i.sym_sync && !bad_q
                     && (trit_cnt == 4'(TRITS_PER_FRAME));
    assign confirm    = match && prev_match_q && (asm_q == frame_o);  // Two equal frames

    always_ff @(posedge clk) begin
        if (enable_i && sym_i.sym_valid && trit_cnt < 4'(TRITS_PER_FRAME))
            asm_q.raw[trit_cnt] <= sym_i.sym_trit;  // Shift in at the next position
        if (frame_take) frame_o <= asm_q;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            trit_cnt     <= '0;
            bad_q        <= 1'b0;
            prev_match_q <= 1'b0;
            frame_done_o <= 1'b0;
            confirm_o    <= 1'b0;
            vt_o         <= 1'b0;
            data_o       <= '0;
        end else begin
            frame_done_o <= 1'b0;
            confirm_o    <= 1'b0;
            if (!enable_i || sym_i.silence) begin
                trit_cnt     <= '0;                 // Drop everything in progress
                bad_q        <= 1'b0;
                prev_match_q <= 1'b0;
                vt_o         <= 1'b0;
            end else if (sym_i.sym_error) begin
                bad_q        <= 1'b1;               // Frame is discarded at its sync
                prev_match_q <= 1'b0;
                vt_o         <= 1'b0;
            end else if (sym_i.sym_valid) begin
                if (trit_cnt <= 4'(TRITS_PER_FRAME)) trit_cnt <= trit_cnt + 1'b1;
            end else if (sym_i.sym_sync) begin
                trit_cnt <= '0;
                bad_q    <= 1'b0;
                if (frame_take) begin
                    frame_done_o <= 1'b1;
                    prev_match_q <= match;
                    if (!match) begin
                        vt_o <= 1'b0;
                    end else if (confirm) begin
                        vt_o      <= 1'b1;
                        confirm_o <= 1'b1;
                        data_o    <= data_nxt;
                    end
                end else begin
                    prev_match_q <= 1'b0;           // Wrong trit count
                    vt_o         <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* pt2272_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module pt2272_apb_regs import pt2272_pkg::*; #(
    parameter int APB_AW = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [APB_AW-1:0] paddr_i,
    input  logic [31:0]       pwdata_i,
    output logic [31:0]       prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    input  logic              frame_done_i,
    input  logic              confirm_i,
    input  logic              vt_i,
    input  pt_frame_u         frame_i,
    input  logic [3:0]        data_i,
    output logic              enable_o,
    output logic [15:0]       addr_cfg_o
);

    logic        access;
    logic        hit;           // Offset is in the map
    logic        read_only;
    logic [31:0] rd_data;
    logic        en_q;
    logic [15:0] addr_q;
    logic        vt_q;
    logic [7:0]  cnt_q;         // Confirmed frames, wraps
    logic [3:0]  data_q;
    pt_frame_u   frame_q;

    assign access = psel_i && penable_i;

    always_comb begin
        hit       = 1'b1;
        read_only = 1'b0;
        rd_data   = '0;
        case (paddr_i)
            APB_AW'(REG_CTRL):   rd_data = {31'b0, en_q};
            APB_AW'(REG_ADDR):   rd_data = {16'b0, addr_q};
            APB_AW'(REG_STATUS): begin
                read_only = 1'b1;
                rd_data   = {16'b0, cnt_q, 7'b0, vt_q};
            end
            APB_AW'(REG_DATA): begin
                read_only = 1'b1;
                rd_data   = {28'b0, data_q};
            end
            APB_AW'(REG_FRAME): begin
                read_only = 1'b1;
                rd_data   = {8'b0, frame_q.raw};
            end
            default: hit = 1'b0;
        endcase
    end

    assign prdata_o  = (access && !pwrite_i) ? rd_data : '0;  // Unmapped reads give zero
    assign pready_o  = 1'b1;                                  // No wait states
    assign pslverr_o = access && (!hit || (pwrite_i && read_only));
    assign enable_o   = en_q;
    assign addr_cfg_o = addr_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            en_q    <= 1'b0;
            addr_q  <= '0;
            vt_q    <= 1'b0;
            cnt_q   <= '0;
            data_q  <= '0;
            frame_q <= '0;
        end else begin
            if (access && pwrite_i && hit && !read_only) begin
                if (paddr_i == APB_AW'(REG_CTRL)) en_q <= pwdata_i[0];
                else addr_q <= pwdata_i[15:0];      // Only ADDR is left writable
            end
            vt_q <= vt_i;                           // Status view lags the pin by one cycle
            if (confirm_i) begin
                cnt_q  <= cnt_q + 1'b1;
                data_q <= data_i;
            end
            if (frame_done_i) frame_q <= frame_i;
        end
    end

endmodule

`default_nettype wire

/* pt2272_decoder_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pt2272_decoder_top import pt2272_pkg::*; #(
    parameter int CLK_PER_ALPHA = 4,
    parameter int APB_AW        = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cod_i,        // Serial code from the encoder
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [APB_AW-1:0] paddr_i,
    input  logic [31:0]       pwdata_i,
    output logic [31:0]       prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    output logic [3:0]        data_o,       // Last confirmed data
    output logic              vt_o          // Valid transmission
);

    logic        enable;
    logic [15:0] addr_cfg;
    logic        frame_done;
    logic        confirm;
    pt_frame_u   frame;

    pt2272_sym_if sym_bus ();

    pt2272_pulse_meter #(
        .CLK_PER_ALPHA(CLK_PER_ALPHA)
    ) u_meter (
        .clk   (clk),
        .reset (reset),
        .cod_i (cod_i),
        .sym_o (sym_bus.meter)
    );

    pt2272_frame_checker u_checker (
        .clk          (clk),
        .reset        (reset),
        .sym_i        (sym_bus.chk),
        .enable_i     (enable),
        .addr_cfg_i   (addr_cfg),
        .frame_done_o (frame_done),
        .frame_o      (frame),
        .confirm_o    (confirm),
        .vt_o         (vt_o),
        .data_o       (data_o)
    );

    pt2272_apb_regs #(
        .APB_AW(APB_AW)
    ) u_regs (
        .clk          (clk),
        .reset        (reset),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .frame_done_i (frame_done),
        .confirm_i    (confirm),
        .vt_i         (vt_o),
        .frame_i      (frame),
        .data_i       (data_o),
        .enable_o     (enable),
        .addr_cfg_o   (addr_cfg)
    );

endmodule

`default_nettype wire

/* tb_pt2272_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pt2272_assert (
    input logic clk,
    input logic reset,
    input logic psel_i,
    input logic penable_i,
    input logic pready_i,
    input logic pslverr_i,
    input logic vt_i,
    input logic confirm_i
);

    logic error_seen;   // Read by the testbench at the end

    initial error_seen = 1'b0;

    a_pready: assert property (@(posedge clk) disable iff (reset) pready_i)
        else begin
            $error("pready_o dropped low");
            error_seen = 1'b1;
        end

    // vt_o and the confirm pulse come from the same edge
    a_vt_rise: assert property (@(posedge clk) disable iff (reset) $rose(vt_i) |-> confirm_i)
        else begin
            $error("vt_o rose without a confirmed frame");
            error_seen = 1'b1;
        end

    a_slverr: assert property (@(posedge clk) disable iff (reset)
                               pslverr_i |-> psel_i && penable_i)
        else begin
            $error("pslverr_o outside an APB access phase");
            error_seen = 1'b1;
        end

endmodule

bind pt2272_decoder_top tb_pt2272_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o),
    .vt_i      (vt_o),
    .confirm_i (confirm)
);

`default_nettype wire

/* tb_pt2272.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pt2272 import pt2272_pkg::*; ();

    localparam int CLK_PER_ALPHA   = 4;
    localparam int APB_AW          = 8;
    localparam int FRAME_CYCLES    = 2048;      // 24 bit-pulses of 64 cycles plus a 512 cycle sync
    localparam int FRAMES_SENT     = 22;        // Over all tests
    localparam int WATCHDOG_CYCLES = FRAMES_SENT * FRAME_CYCLES + 20000;
    localparam int VT_WAIT_CYCLES  = FRAME_CYCLES;
    localparam logic [15:0] ADDR_CFG   = 16'h33C3;  // Trits One,Zero,Zero,One,One,Zero,One,Zero
    localparam logic [15:0] ADDR_FLOAT = 16'h33D3;  // Same with trit 2 Float
    localparam logic [7:0]  UNMAPPED   = 8'h14;

    logic        clk;
    logic        reset;
    logic        cod_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    logic [7:0]  paddr_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic [3:0]  data_o;
    logic        vt_o;
    logic [31:0] seed;
    int          confirms;      // Confirmations expected so far
    logic [3:0]  last_data;     // Data of the last confirmed frame

    pt2272_decoder_top #(
        .CLK_PER_ALPHA(CLK_PER_ALPHA),
        .APB_AW       (APB_AW)
    ) dut0 (
        .clk       (clk),
        .reset     (reset),
        .cod_i     (cod_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .data_o    (data_o),
        .vt_o      (vt_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure("Watchdog expired, the tests did not finish in time");
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Random data trits, One or Zero only
    function automatic logic [7:0] random_data();
        logic [7:0]  code;
        logic [31:0] r;
        code = '0;
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            code[2*i +: 2] = r[20] ? 2'b11 : 2'b00;
        end
        return code;
    endfunction

    function automatic pt_frame_u make_frame(input logic [15:0] addr, input logic [7:0] data);
        return pt_frame_u'({data, addr});       // Data trits above the address trits
    endfunction

    function automatic logic [3:0] data_bits(input pt_frame_u f);
        logic [3:0] bits;
        for (int i = 0; i < 4; i++)
            bits[i] = (f.fields.data[i] == TRIT_ONE);
        return bits;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
            stop_with_failure($sformatf("FAILED %s expected %h got %h", name, exp, act));
    endtask

    task automatic check_frame(input string name, input pt_frame_u exp, input pt_frame_u act);
        if (act !== exp)
            stop_with_failure($sformatf("FAILED %s expected %h got %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_with_failure($sformatf("FAILED %s expected %h got %h", name, exp, act));
    endtask

    // One APB transfer, starts and ends just after a rising edge
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, input logic exp_err,
                              output logic [31:0] rdata);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= write;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk);
        penable_i <= 1'b1;                      // Access phase
        @(negedge clk);
        rdata = prdata_o;
        check_flag("pslverr_o", exp_err, pslverr_o);
        check_flag("pready_o", 1'b1, pready_o);
        @(posedge clk);                         // No wait states
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            input logic exp_err);
        apb_access(1'b0, addr, 32'h0, exp_err, data);
    endtask

    task automatic idle_line(input int alphas);
        repeat (alphas * CLK_PER_ALPHA) @(posedge clk);
    endtask

    task automatic send_pulse(input int high_alphas, input int low_alphas);
        cod_i <= 1'b1;
        repeat (high_alphas * CLK_PER_ALPHA) @(posedge clk);
        cod_i <= 1'b0;
        repeat (low_alphas * CLK_PER_ALPHA) @(posedge clk);
    endtask

    task automatic send_bit(input logic b);
        if (b)
            send_pulse(LONG_ALPHA, SHORT_ALPHA);
        else
            send_pulse(SHORT_ALPHA, LONG_ALPHA);
    endtask

    task automatic send_trit(input pt_trit_e t);
        case (t)
            TRIT_ZERO: begin
                send_bit(1'b0);
                send_bit(1'b0);
            end
            TRIT_ONE: begin
                send_bit(1'b1);
                send_bit(1'b1);
            end
            TRIT_FLOAT: begin
                send_bit(1'b0);
                send_bit(1'b1);
            end
            default: begin                      // Pair 1,0 is never sent by an encoder
                send_bit(1'b1);
                send_bit(1'b0);
            end
        endcase
    endtask

    task automatic send_sync();
        send_pulse(SHORT_ALPHA, SYNC_LOW_ALPHA);
    endtask

    task automatic send_frame(input pt_frame_u f);
        for (int i = 0; i < TRITS_PER_FRAME; i++)
            send_trit(f.raw[i]);                // Trit 0 goes first
        send_sync();
    endtask

    task automatic send_bad_pulse();
        send_pulse(SHORT_ALPHA + TOL_ALPHA + 2, LONG_ALPHA);  // High fits neither window
    endtask

    task automatic wait_vt(input logic exp, input string when);
        int n;
        n = 0;
        @(negedge clk);
        while (vt_o !== exp) begin
            if (n == VT_WAIT_CYCLES)
                stop_with_failure({"Timeout, vt_o did not reach its value ", when});
            n++;
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic check_outputs(input logic exp_vt, input logic [3:0] exp_data);
        @(negedge clk);
        check_flag("vt_o", exp_vt, vt_o);
        check_word("data_o", {28'h0, exp_data}, {28'h0, data_o});
        @(posedge clk);
    endtask

    task automatic check_regs(input logic exp_vt, input pt_frame_u exp_frame);
        logic [31:0] rd;
        apb_read(REG_STATUS, rd, 1'b0);
        check_word("STATUS", {16'h0, 8'(confirms), 7'h0, exp_vt}, rd);  // Count in 15:8
        apb_read(REG_DATA, rd, 1'b0);
        check_word("DATA", {28'h0, last_data}, rd);
        apb_read(REG_FRAME, rd, 1'b0);
        check_frame("FRAME", exp_frame, pt_frame_u'(rd[23:0]));
        check_word("FRAME upper byte", 32'h0, {24'h0, rd[31:24]});
    endtask

    // Two equal matching frames in a row
    task automatic confirm_pair(input pt_frame_u f);
        send_frame(f);
        send_frame(f);
        wait_vt(1'b1, "after two equal frames");
        confirms++;
        last_data = data_bits(f);
        check_outputs(1'b1, last_data);
        check_regs(1'b1, f);
    endtask

    task automatic test_registers();
        logic [31:0] rd;
        check_outputs(1'b0, 4'h0);
        apb_read(REG_CTRL, rd, 1'b0);
        check_word("CTRL", 32'h0, rd);
        apb_read(REG_ADDR, rd, 1'b0);
        check_word("ADDR", 32'h0, rd);
        check_regs(1'b0, '0);
        apb_write(REG_ADDR, {16'h0, ADDR_CFG}, 1'b0);
        apb_read(REG_ADDR, rd, 1'b0);
        check_word("ADDR", {16'h0, ADDR_CFG}, rd);
        apb_write(REG_CTRL, 32'h1, 1'b0);
        apb_read(REG_CTRL, rd, 1'b0);
        check_word("CTRL", 32'h1, rd);
        apb_read(UNMAPPED, rd, 1'b1);
        check_word("prdata_o", 32'h0, rd);      // Unmapped read returns zero
        apb_write(REG_STATUS, 32'hFFFF_FFFF, 1'b1);
        check_regs(1'b0, '0);
    endtask

    task automatic test_single_and_mismatch();
        logic [7:0] d;
        pt_frame_u  f;
        pt_frame_u  g;
        d = random_data();
        f = make_frame(ADDR_CFG, d);
        g = make_frame(ADDR_CFG ^ 16'h0003, d); // Trit 0 Zero instead of One
        idle_line(SILENCE_ALPHA + 8);           // Earlier frames forgotten
        send_frame(f);
        check_outputs(1'b0, last_data);
        check_regs(1'b0, f);
        send_frame(f);
        wait_vt(1'b1, "after the repeated frame");
        confirms++;
        last_data = data_bits(f);
        check_outputs(1'b1, last_data);
        send_frame(g);
        wait_vt(1'b0, "after a frame with another address");
        check_regs(1'b0, g);
    endtask

    task automatic test_float();
        logic [7:0] d;
        logic [7:0] d_float;
        d       = random_data();
        d_float = (d & 8'hF3) | 8'h04;          // Data trit 1 Float
        apb_write(REG_ADDR, {16'h0, ADDR_FLOAT}, 1'b0);
        confirm_pair(make_frame(ADDR_FLOAT, d));
        send_frame(make_frame(ADDR_CFG, d));    // Zero against a Float trit
        wait_vt(1'b0, "after Zero sent to a Float trit");
        apb_write(REG_ADDR, {16'h0, ADDR_CFG}, 1'b0);
        send_frame(make_frame(ADDR_FLOAT, d));  // Float against a Zero trit
        send_frame(make_frame(ADDR_FLOAT, d));
        check_outputs(1'b0, last_data);
        send_frame(make_frame(ADDR_CFG, d_float));
        send_frame(make_frame(ADDR_CFG, d_float));
        check_outputs(1'b0, last_data);
        check_regs(1'b0, make_frame(ADDR_CFG, d_float));
    endtask

    task automatic test_malformed();
        logic [7:0] d;
        pt_frame_u  f;
        pt_frame_u  g;
        d = random_data();
        f = make_frame(ADDR_CFG, d);
        g = make_frame(ADDR_CFG, ~d);           // Differs from f in every data trit
        confirm_pair(f);
        for (int i = 0; i < TRITS_PER_FRAME; i++) begin
            if (i == 5)
                send_bad_pulse();
            send_trit(g.raw[i]);
        end
        send_sync();
        check_outputs(1'b0, last_data);
        check_regs(1'b0, f);
        confirm_pair(f);
        for (int i = 0; i < TRITS_PER_FRAME - 1; i++)
            send_trit(g.raw[i]);                // Last trit left out
        send_sync();
        check_outputs(1'b0, last_data);
        check_regs(1'b0, f);
    endtask

    task automatic test_silence_and_disable();
        logic [7:0] d;
        pt_frame_u  f;
        pt_frame_u  g;
        d = random_data();
        f = make_frame(ADDR_CFG, d);
        g = make_frame(ADDR_CFG, ~d);
        confirm_pair(f);
        idle_line(SILENCE_ALPHA);
        wait_vt(1'b0, "during silence");
        check_regs(1'b0, f);
        apb_write(REG_CTRL, 32'h0, 1'b0);
        send_frame(g);
        send_frame(g);
        check_outputs(1'b0, last_data);
        check_regs(1'b0, f);                    // Disabled decoder keeps the old frame
    endtask

    initial begin
        seed      = 32'hf166;
        confirms  = 0;
        last_data = 4'h0;
        reset     = 1'b1;
        cod_i     = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = 8'h0;
        pwdata_i  = 32'h0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        test_registers();
        confirm_pair(make_frame(ADDR_CFG, random_data()));
        test_single_and_mismatch();
        test_float();
        test_malformed();
        test_silence_and_disable();
        if (dut0.u_assert.error_seen) begin
            stop_with_failure("A protocol assertion failed during the run");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* flist.f */
pt2272_pkg.sv
pt2272_sym_if.sv
pt2272_pulse_meter.sv
pt2272_frame_checker.sv
pt2272_apb_regs.sv
pt2272_decoder_top.sv
tb_pt2272_assert.sv
tb_pt2272.sv
